// File: sprite_pkg.sv
// Fixed 8-bit line address caps a line at 256 pixels; index 0 is always transparent.
package sprite_pkg;

	// Line address width.
	// Limits one line to 256 pixels.
	localparam int ADDR_W = 8;

	// Colour index per pixel.
	// Index 0 means transparent and is never written.
	localparam int INDEX_W = 4;

	// Palette number per strip.
	localparam int PAL_W = 8;

	// Stored pixel.
	// Palette in the upper bits, index in the lower bits.
	localparam int PIX_W = PAL_W + INDEX_W;

	// Pixels carried by one strip command.
	localparam int STRIP_LEN = 16;

	// Packed strip indices.
	// Pixel 0 sits in the lowest nibble.
	localparam int STRIP_W = STRIP_LEN * INDEX_W;

	// Cleared pixel code.
	// All ones, as left behind by the scanout.
	localparam logic [PIX_W-1:0] BACKDROP = '1;

	// Transparent index value.
	localparam logic [INDEX_W-1:0] INDEX_CLEAR = '0;

endpackage

// File: spram.sv
// Read-first single-port RAM; no reset, so contents are unknown until written.
module spram #(
	parameter int ADDR_BITS = 8,
	parameter int DATA_BITS = 12
) (
	input  logic                 CLK,
	input  logic [ADDR_BITS-1:0] address,
	input  logic [DATA_BITS-1:0] data,
	input  logic                 wren,
	output logic [DATA_BITS-1:0] q
);

	localparam int DEPTH = 2 ** ADDR_BITS;

	// Storage array.
	logic [DATA_BITS-1:0] mem [DEPTH];

	// Write port.
	always_ff @(posedge CLK) begin
		if (wren) begin
			mem[address] <= data;
		end
	end

	// Registered read every cycle.
	// On a write cycle q picks up the old word.
	always_ff @(posedge CLK) begin
		q <= mem[address];
	end

endmodule

// File: sprite_line_writer.sv
// One strip in flight; no back-pressure, so cmd_valid while busy is dropped and asserted on.
module sprite_line_writer (
	input  logic                           CLK,
	input  logic                           rst_n,
	input  logic                           cmd_valid,
	input  logic [sprite_pkg::ADDR_W-1:0]  cmd_x,
	input  logic [sprite_pkg::PAL_W-1:0]   cmd_pal,
	input  logic [sprite_pkg::STRIP_W-1:0] cmd_pixels,
	output logic                           render_busy,
	output logic                           wr_pal_en,
	output logic [sprite_pkg::PAL_W-1:0]   wr_pal,
	output logic                           wr_load,
	output logic [sprite_pkg::ADDR_W-1:0]  wr_addr,
	output logic                           wr_step,
	output logic                           wr_we,
	output logic [sprite_pkg::INDEX_W-1:0] wr_index
);

	import sprite_pkg::*;

	localparam int CNT_W = $clog2(STRIP_LEN);
	localparam logic [CNT_W-1:0] LAST_PIX = CNT_W'(STRIP_LEN - 1);

	// Strip in progress.
	logic busy_q;
	// Pixel number being presented.
	logic [CNT_W-1:0] cnt_q;
	// Remaining indices, current one at the bottom.
	logic [STRIP_W-1:0] shift_q;
	// Start x of the strip.
	logic [ADDR_W-1:0] x_q;
	logic accept;

	// Command taken only when idle.
	assign accept = cmd_valid && !busy_q;

	// Busy covers the accept cycle plus 16 pixel cycles.
	assign render_busy = busy_q || cmd_valid;

	// Palette goes out in the accept cycle.
	// The buffer latches it at the end of that cycle.
	assign wr_pal_en = accept;
	assign wr_pal = cmd_pal;

	// Control sequencing.
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			busy_q <= 1'b0;
			cnt_q <= '0;
		end else if (accept) begin
			busy_q <= 1'b1;
			cnt_q <= '0;
		end else if (busy_q) begin
			cnt_q <= cnt_q + 1'b1;
			// Last pixel presented.
			if (cnt_q == LAST_PIX) begin
				busy_q <= 1'b0;
			end
		end
	end

	// Strip payload.
	always_ff @(posedge CLK) begin
		if (accept) begin
			shift_q <= cmd_pixels;
			x_q <= cmd_x;
		end else if (busy_q) begin
			// Next index into the low nibble.
			shift_q <= shift_q >> INDEX_W;
		end
	end

	// First pixel reloads the address, the rest step it.
	assign wr_load = busy_q && (cnt_q == '0);
	assign wr_step = busy_q && (cnt_q != '0);
	assign wr_addr = x_q;

	// Current index.
	assign wr_index = shift_q[INDEX_W-1:0];

	// Transparent pixels leave the line untouched.
	// Earlier sprites show through.
	assign wr_we = busy_q && (wr_index != INDEX_CLEAR);

	// A new strip may only start once the previous one is finished.
	a_no_cmd_while_busy: assert property (
		@(posedge CLK) disable iff (!rst_n)
		cmd_valid |-> !busy_q
	) else $error("sprite_line_writer: strip command while busy");

endmodule

// File: line_buffer.sv
// Addresses must stay below LINE_PIXELS; strips may not wrap past the line end.
module line_buffer #(
	parameter int LINE_PIXELS = 192
) (
	input  logic                           CLK,
	input  logic                           rst_n,
	input  logic                           display,
	input  logic                           pal_en,
	input  logic [sprite_pkg::PAL_W-1:0]   pal,
	input  logic                           wr_load,
	input  logic [sprite_pkg::ADDR_W-1:0]  wr_addr,
	input  logic                           wr_step,
	input  logic                           wr_we,
	input  logic [sprite_pkg::INDEX_W-1:0] wr_index,
	input  logic                           rd_load,
	input  logic                           rd_step,
	input  logic                           rd_we,
	output logic [sprite_pkg::PIX_W-1:0]   data_out
);

	import sprite_pkg::*;

	// Palette of the strip being rendered.
	logic [PAL_W-1:0] pal_q;
	// Address counter.
	logic [ADDR_W-1:0] addr_q;
	logic [ADDR_W-1:0] addr_mux;
	logic [ADDR_W-1:0] addr_load;
	logic load;
	logic step;
	logic we;
	logic [PIX_W-1:0] data_in;

	// Palette latch.
	// Only the rendering buffer takes it.
	always_ff @(posedge CLK) begin
		if (pal_en && !display) begin
			pal_q <= pal;
		end
	end

	// Role select between render bus and display bus.
	assign load = display ? rd_load : wr_load;
	assign step = display ? rd_step : wr_step;
	assign we = display ? rd_we : wr_we;

	// Display always starts at x = 0.
	assign addr_load = display ? '0 : wr_addr;

	// Clearing writes backdrop behind the scan.
	assign data_in = display ? BACKDROP : {pal_q, wr_index};

	// Load beats step, step beats hold.
	assign addr_mux = load ? addr_load : (step ? addr_q + 1'b1 : addr_q);

	// Counter keeps the address used this cycle.
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			addr_q <= '0;
		end else begin
			addr_q <= addr_mux;
		end
	end

	// Line storage, accessed at the muxed address this cycle.
	spram #(
		.ADDR_BITS(ADDR_W),
		.DATA_BITS(PIX_W)
	) u_ram (
		.CLK(CLK),
		.address(addr_mux),
		.data(data_in),
		.wren(we),
		.q(data_out)
	);

	// Writer and scanout addresses both stay inside the visible line.
	a_addr_in_line: assert property (
		@(posedge CLK) disable iff (!rst_n)
		(load || step || we) |-> (int'(addr_mux) < LINE_PIXELS)
	) else $error("line_buffer: access at x=%0d past line end", addr_mux);

endmodule

// File: line_scanout.sv
// Two cycles per pixel, no stall; line_start during a scan is ignored and asserted on.
module line_scanout #(
	parameter int LINE_PIXELS = 192
) (
	input  logic                          CLK,
	input  logic                          rst_n,
	input  logic                          line_start,
	input  logic [sprite_pkg::PIX_W-1:0]  rd_data,
	output logic                          rd_load,
	output logic                          rd_step,
	output logic                          rd_we,
	output logic                          pix_valid,
	output logic [sprite_pkg::ADDR_W-1:0] pix_x,
	output logic [sprite_pkg::PIX_W-1:0]  pix_color,
	output logic                          line_done
);

	import sprite_pkg::*;

	localparam logic [ADDR_W-1:0] LAST_X = ADDR_W'(LINE_PIXELS - 1);

	// Scan running.
	logic active_q;
	// Low in the read phase, high in the clear phase.
	logic phase_q;
	// Current pixel position.
	logic [ADDR_W-1:0] x_q;
	// End of line pulse.
	logic done_q;
	logic read_phase;
	logic clear_phase;

	assign read_phase = active_q && !phase_q;
	assign clear_phase = active_q && phase_q;

	// Read then clear for each x.
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			active_q <= 1'b0;
			phase_q <= 1'b0;
			x_q <= '0;
			done_q <= 1'b0;
		end else begin
			done_q <= 1'b0;
			if (!active_q) begin
				if (line_start) begin
					active_q <= 1'b1;
					phase_q <= 1'b0;
					x_q <= '0;
				end
			end else if (!phase_q) begin
				phase_q <= 1'b1;
			end else begin
				phase_q <= 1'b0;
				// Last pixel cleared, end the line.
				if (x_q == LAST_X) begin
					active_q <= 1'b0;
					done_q <= 1'b1;
				end else begin
					x_q <= x_q + 1'b1;
				end
			end
		end
	end

	// First read loads address 0, later reads step.
	assign rd_load = read_phase && (x_q == '0);
	assign rd_step = read_phase && (x_q != '0);

	// Clear the location just read.
	assign rd_we = clear_phase;

	// RAM output is valid in the clear phase.
	assign pix_valid = clear_phase;
	assign pix_x = x_q;
	assign pix_color = rd_data;
	assign line_done = done_q;

	// No restart while a line is being scanned.
	a_no_start_mid_scan: assert property (
		@(posedge CLK) disable iff (!rst_n)
		line_start |-> !active_q
	) else $error("line_scanout: line_start during a scan");

endmodule

// File: sprite_line_top.sv
// line_sel may only change while render_busy is low and no scan is running.
module sprite_line_top #(
	parameter int LINE_PIXELS = 192
) (
	input  logic                           CLK,
	input  logic                           rst_n,
	input  logic                           cmd_valid,
	input  logic [sprite_pkg::ADDR_W-1:0]  cmd_x,
	input  logic [sprite_pkg::PAL_W-1:0]   cmd_pal,
	input  logic [sprite_pkg::STRIP_W-1:0] cmd_pixels,
	output logic                           render_busy,
	input  logic                           line_sel,
	input  logic                           line_start,
	output logic                           pix_valid,
	output logic [sprite_pkg::ADDR_W-1:0]  pix_x,
	output logic [sprite_pkg::PIX_W-1:0]   pix_color,
	output logic                           line_done
);

	import sprite_pkg::*;

	// Render bus, shared by both buffers.
	logic wr_pal_en;
	logic [PAL_W-1:0] wr_pal;
	logic wr_load;
	logic [ADDR_W-1:0] wr_addr;
	logic wr_step;
	logic wr_we;
	logic [INDEX_W-1:0] wr_index;

	// Display bus, shared by both buffers.
	logic rd_load;
	logic rd_step;
	logic rd_we;

	logic [PIX_W-1:0] lb0_data;
	logic [PIX_W-1:0] lb1_data;
	logic [PIX_W-1:0] rd_data;

	sprite_line_writer u_writer (
		.CLK(CLK),
		.rst_n(rst_n),
		.cmd_valid(cmd_valid),
		.cmd_x(cmd_x),
		.cmd_pal(cmd_pal),
		.cmd_pixels(cmd_pixels),
		.render_busy(render_busy),
		.wr_pal_en(wr_pal_en),
		.wr_pal(wr_pal),
		.wr_load(wr_load),
		.wr_addr(wr_addr),
		.wr_step(wr_step),
		.wr_we(wr_we),
		.wr_index(wr_index)
	);

	// Buffer 0 displays when line_sel is high.
	line_buffer #(.LINE_PIXELS(LINE_PIXELS)) lb0 (
		.CLK(CLK), .rst_n(rst_n), .display(line_sel),
		.pal_en(wr_pal_en), .pal(wr_pal),
		.wr_load(wr_load), .wr_addr(wr_addr), .wr_step(wr_step),
		.wr_we(wr_we), .wr_index(wr_index),
		.rd_load(rd_load), .rd_step(rd_step), .rd_we(rd_we),
		.data_out(lb0_data)
	);

	// Buffer 1 takes the opposite role.
	line_buffer #(.LINE_PIXELS(LINE_PIXELS)) lb1 (
		.CLK(CLK), .rst_n(rst_n), .display(!line_sel),
		.pal_en(wr_pal_en), .pal(wr_pal),
		.wr_load(wr_load), .wr_addr(wr_addr), .wr_step(wr_step),
		.wr_we(wr_we), .wr_index(wr_index),
		.rd_load(rd_load), .rd_step(rd_step), .rd_we(rd_we),
		.data_out(lb1_data)
	);

	// Scanout sees the displaying buffer.
	assign rd_data = line_sel ? lb0_data : lb1_data;

	line_scanout #(.LINE_PIXELS(LINE_PIXELS)) u_scanout (
		.CLK(CLK),
		.rst_n(rst_n),
		.line_start(line_start),
		.rd_data(rd_data),
		.rd_load(rd_load),
		.rd_step(rd_step),
		.rd_we(rd_we),
		.pix_valid(pix_valid),
		.pix_x(pix_x),
		.pix_color(pix_color),
		.line_done(line_done)
	);

endmodule

// File: tb_sprite_line.sv
// Runs LINE_PIXELS at 64 with every strip inside the line; the first scan of each buffer clears unknown RAM.
module tb_sprite_line;

	import sprite_pkg::*;

	localparam int LINE_PIXELS = 64;
	localparam int CLK_PERIOD = 40;
	localparam int DRIVE_DLY = 2;
	localparam int NUM_SCN = 4;
	localparam int SCN_CMDS = 3;
	localparam int NUM_CMDS = NUM_SCN * SCN_CMDS;
	localparam int BUSY_LIMIT = 64;
	localparam int SCAN_LIMIT = 2 * LINE_PIXELS + 16;

	logic CLK;
	logic rst_n;
	logic cmd_valid;
	logic [ADDR_W-1:0] cmd_x;
	logic [PAL_W-1:0] cmd_pal;
	logic [STRIP_W-1:0] cmd_pixels;
	logic render_busy;
	logic line_sel;
	logic line_start;
	logic pix_valid;
	logic [ADDR_W-1:0] pix_x;
	logic [PIX_W-1:0] pix_color;
	logic line_done;

	int errors;
	int checks;
	int seed;
	string scan_name;

	// Strip command table, SCN_CMDS entries per line scenario.
	logic [ADDR_W-1:0] tab_x [NUM_CMDS];
	logic [PAL_W-1:0] tab_pal [NUM_CMDS];
	logic [STRIP_W-1:0] tab_pix [NUM_CMDS];

	// Reference contents of buffer 0 and buffer 1.
	logic [PIX_W-1:0] ref_line [2][LINE_PIXELS];

	sprite_line_top #(.LINE_PIXELS(LINE_PIXELS)) UUT (
		.CLK(CLK), .rst_n(rst_n),
		.cmd_valid(cmd_valid), .cmd_x(cmd_x), .cmd_pal(cmd_pal), .cmd_pixels(cmd_pixels),
		.render_busy(render_busy), .line_sel(line_sel), .line_start(line_start),
		.pix_valid(pix_valid), .pix_x(pix_x), .pix_color(pix_color), .line_done(line_done)
	);

	initial begin
		CLK = 1'b0;
		forever #(CLK_PERIOD / 2) CLK = ~CLK;
	end

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	// Overlap cases fixed, the last two scenarios random.
	task automatic fill_table;
		logic [31:0] r;
		tab_x[0] = 8'd4;
		tab_pal[0] = 8'h21;
		tab_pix[0] = 64'h0123_4567_89ab_cdef;
		// Overlaps x 12..19, holes at x 13 and 15.
		tab_x[1] = 8'd12;
		tab_pal[1] = 8'h5a;
		tab_pix[1] = 64'h1111_0000_2222_0303;
		// Right edge of the line.
		tab_x[2] = 8'd48;
		tab_pal[2] = 8'hc3;
		tab_pix[2] = 64'hfedc_ba98_7654_3210;
		// Same x stacked three deep.
		tab_x[3] = 8'd20;
		tab_pal[3] = 8'h01;
		tab_pix[3] = 64'h7777_7777_7777_7777;
		tab_x[4] = 8'd20;
		tab_pal[4] = 8'h02;
		tab_pix[4] = 64'h0000_0000_8888_8888;
		tab_x[5] = 8'd24;
		tab_pal[5] = 8'h03;
		tab_pix[5] = 64'h9090_9090_9090_9090;
		for (int i = 2 * SCN_CMDS; i < NUM_CMDS; i++) begin
			r = $random(seed);
			tab_x[i] = r % (LINE_PIXELS - STRIP_LEN + 1);
			tab_pal[i] = r[15:8];
			// About a quarter of the pixels transparent.
			for (int j = 0; j < STRIP_LEN; j++) begin
				r = $random(seed);
				if (r[1:0] == 2'd0) begin
					tab_pix[i][j*INDEX_W +: INDEX_W] = '0;
				end else begin
					tab_pix[i][j*INDEX_W +: INDEX_W] = r[7:4];
				end
			end
		end
	endtask

	// Opaque pixels overwrite, index 0 leaves the old entry.
	task automatic paint_strip(input int b, input int i);
		logic [INDEX_W-1:0] idx;
		for (int j = 0; j < STRIP_LEN; j++) begin
			idx = tab_pix[i][j*INDEX_W +: INDEX_W];
			if (idx != 0) begin
				ref_line[b][tab_x[i] + j] = {tab_pal[i], idx};
			end
		end
	endtask

	task automatic set_sel(input bit v);
		@(posedge CLK);
		#DRIVE_DLY;
		line_sel = v;
	endtask

	// Buffer 0 renders while line_sel is low.
	task automatic render_scenario(input int s);
		int b;
		int k;
		int wait_cnt;
		b = line_sel;
		for (int c = 0; c < SCN_CMDS; c++) begin
			k = s * SCN_CMDS + c;
			@(posedge CLK);
			#DRIVE_DLY;
			cmd_valid = 1'b1;
			cmd_x = tab_x[k];
			cmd_pal = tab_pal[k];
			cmd_pixels = tab_pix[k];
			paint_strip(b, k);
			// Busy already in the accept cycle.
			@(negedge CLK);
			check_val($sformatf("strip%0d busy at accept", k), 1, render_busy);
			@(posedge CLK);
			#DRIVE_DLY;
			cmd_valid = 1'b0;
			wait_cnt = 0;
			@(negedge CLK);
			while (render_busy && wait_cnt < BUSY_LIMIT) begin
				@(negedge CLK);
				wait_cnt++;
			end
			if (render_busy) begin
				errors++;
				$display("Timeout: render_busy stayed high after strip %0d", k);
			end else begin
				// High through pixel cycles 1 to 16, low from cycle 17.
				check_val($sformatf("strip%0d busy length", k), STRIP_LEN, wait_cnt);
			end
		end
	endtask

	// Scan collector, sampled on the falling edge.
	task automatic scan_line(input string name, input bit check_color);
		int b;
		int n;
		int wait_cnt;
		bit done;
		b = line_sel ? 0 : 1;
		n = 0;
		wait_cnt = 0;
		done = 1'b0;
		@(posedge CLK);
		#DRIVE_DLY;
		line_start = 1'b1;
		@(posedge CLK);
		#DRIVE_DLY;
		line_start = 1'b0;
		while (!done && wait_cnt < SCAN_LIMIT) begin
			@(negedge CLK);
			wait_cnt++;
			if (pix_valid) begin
				check_val({name, " pix_x"}, n, pix_x);
				if (check_color && n < LINE_PIXELS) begin
					check_val($sformatf("%s x=%0d", name, n), ref_line[b][n], pix_color);
				end
				// Scanout leaves backdrop behind.
				if (n < LINE_PIXELS) begin
					ref_line[b][n] = BACKDROP;
				end
				n++;
			end
			if (line_done) begin
				done = 1'b1;
			end
		end
		if (!done) begin
			errors++;
			$display("Timeout: scan %s never raised line_done", name);
		end else begin
			check_val({name, " pixel count"}, LINE_PIXELS, n);
			// Pulse lasts one cycle.
			@(negedge CLK);
			check_val({name, " line_done width"}, 0, line_done);
		end
	endtask

	initial begin
		seed = 32'hd7a49447;
		errors = 0;
		checks = 0;
		rst_n = 1'b0;
		cmd_valid = 1'b0;
		cmd_x = '0;
		cmd_pal = '0;
		cmd_pixels = '0;
		line_sel = 1'b0;
		line_start = 1'b0;
		fill_table();
		repeat (5) @(posedge CLK);
		#DRIVE_DLY;
		rst_n = 1'b1;

		// Flush unknown RAM, then expect blank lines.
		scan_line("flush1", 1'b0);
		set_sel(1'b1);
		scan_line("flush0", 1'b0);
		scan_line("blank0", 1'b1);
		set_sel(1'b0);
		scan_line("blank1", 1'b1);

		// Ping-pong through the scenarios.
		render_scenario(0);
		for (int s = 1; s < NUM_SCN; s++) begin
			set_sel(!line_sel);
			scan_name = $sformatf("line%0d", s - 1);
			fork
				scan_line(scan_name, 1'b1);
				render_scenario(s);
			join
		end
		set_sel(!line_sel);
		scan_line($sformatf("line%0d", NUM_SCN - 1), 1'b1);
		// Same buffer again, no render in between.
		scan_line("rescan", 1'b1);

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// File: build.f
sprite_pkg.sv
spram.sv
sprite_line_writer.sv
line_buffer.sv
line_scanout.sv
sprite_line_top.sv
tb_sprite_line.sv

// File: Bender.yml
package:
  name: sprite_line

sources:
  - sprite_pkg.sv
  - spram.sv
  - sprite_line_writer.sv
  - line_buffer.sv
  - line_scanout.sv
  - sprite_line_top.sv
  - target: test
    files:
      - tb_sprite_line.sv
